// ==== design/kbd_regs.sv ====
// Host register block with four-phase req/ack port, control bits, status and error counter
`timescale 1ns/100ps

module kbd_regs (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              req,
    input  logic                              wr,
    input  logic [ps2_kbd_pkg::addr_w-1:0]    addr,
    input  logic [ps2_kbd_pkg::data_w-1:0]    wdata,
    output logic                              ack,
    output logic [ps2_kbd_pkg::data_w-1:0]    rdata,
    input  logic                              frame_err,
    input  ps2_kbd_pkg::key_event_t           head,
    input  logic [ps2_kbd_pkg::fifo_aw:0]     level,
    input  logic                              overflow,
    output logic                              pop,
    output logic                              ovf_clr,
    output logic                              ctrl_enable,
    output logic                              ctrl_parity
);

    import ps2_kbd_pkg::*;

    logic                 start;
    logic                 not_empty;
    logic [err_cnt_w-1:0] err_cnt;
    logic [data_w-1:0]    rd_mux;

    // New request seen while ack is still low
    assign start     = req && !ack;
    assign not_empty = (level != '0);

    // ----------------------------------------------------------------------
    // Handshake and side effects
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack         <= 1'b0;
            pop         <= 1'b0;
            ovf_clr     <= 1'b0;
            ctrl_enable <= ctrl_rst_val[0];
            ctrl_parity <= ctrl_rst_val[1];
        end else begin
            pop     <= 1'b0;
            ovf_clr <= 1'b0;
            if (start) begin
                ack <= 1'b1;
                if (wr) begin
                    if (addr == reg_ctrl) begin
                        ctrl_enable <= wdata[0];
                        ctrl_parity <= wdata[1];
                    end
                end else begin
                    // Read side effects fire once, with the rising ack
                    pop     <= (addr == reg_event) && not_empty;
                    ovf_clr <= (addr == reg_status);
                end
            end else if (!req && ack) begin
                ack <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Error counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_cnt <= '0;
        end else if (start && wr && addr == reg_errors) begin
            // Clear wins over a coincident error
            err_cnt <= '0;
        end else if (frame_err && err_cnt != '1) begin
            err_cnt <= err_cnt + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Read data
    // ----------------------------------------------------------------------
    always_comb begin
        case (addr)
            reg_ctrl:   rd_mux = data_w'({ctrl_parity, ctrl_enable});
            reg_status: rd_mux = data_w'({not_empty, overflow, level});
            // Empty FIFO reads as zero
            reg_event:  rd_mux = not_empty ? data_w'(head.raw) : '0;
            default:    rd_mux = data_w'(err_cnt);
        endcase
    end

    // Held stable for the whole ack phase
    always_ff @(posedge clk) begin
        if (start && !wr) begin
            rdata <= rd_mux;
        end
    end

endmodule

// ==== design/kbd_top.sv ====
// Top level joining the frame receiver, scan decoder, event FIFO and host registers
`timescale 1ns/100ps

module kbd_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           ps2_clk,
    input  logic                           ps2_data,
    input  logic                           req,
    input  logic                           wr,
    input  logic [ps2_kbd_pkg::addr_w-1:0] addr,
    input  logic [ps2_kbd_pkg::data_w-1:0] wdata,
    output logic                           ack,
    output logic [ps2_kbd_pkg::data_w-1:0] rdata
);

    import ps2_kbd_pkg::*;

    // ----------------------------------------------------------------------
    // Internal nets
    // ----------------------------------------------------------------------

    // Receiver to decoder
    logic [7:0] rx_byte;
    logic       byte_valid;
    logic       frame_err;

    // Decoder to FIFO
    key_event_t ev_data;
    logic       ev_push;

    // FIFO to register block
    key_event_t       head;
    logic [fifo_aw:0] level;
    logic             overflow;
    logic             pop;
    logic             ovf_clr;

    // Configuration back to the receiver
    logic ctrl_enable;
    logic ctrl_parity;

    // ----------------------------------------------------------------------
    // Receive path
    // ----------------------------------------------------------------------
    ps2_frame_rx u_frame_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .ctrl_enable (ctrl_enable),
        .ctrl_parity (ctrl_parity),
        .rx_byte     (rx_byte),
        .byte_valid  (byte_valid),
        .frame_err   (frame_err)
    );

    scan_decoder u_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid),
        .ev_data    (ev_data),
        .ev_push    (ev_push)
    );

    key_event_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (ev_push),
        .push_data (ev_data),
        .pop       (pop),
        .head      (head),
        .level     (level),
        .overflow  (overflow),
        .ovf_clr   (ovf_clr)
    );

    // Host side, steers the receiver
    kbd_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .wr          (wr),
        .addr        (addr),
        .wdata       (wdata),
        .ack         (ack),
        .rdata       (rdata),
        .frame_err   (frame_err),
        .head        (head),
        .level       (level),
        .overflow    (overflow),
        .pop         (pop),
        .ovf_clr     (ovf_clr),
        .ctrl_enable (ctrl_enable),
        .ctrl_parity (ctrl_parity)
    );

endmodule

// ==== design/key_event_fifo.sv ====
// Circular key event buffer with fill level and sticky overflow flag
`timescale 1ns/100ps

module key_event_fifo (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          push,
    input  ps2_kbd_pkg::key_event_t       push_data,
    input  logic                          pop,
    output ps2_kbd_pkg::key_event_t       head,
    output logic [ps2_kbd_pkg::fifo_aw:0] level,
    output logic                          overflow,
    input  logic                          ovf_clr
);

    import ps2_kbd_pkg::*;

    // Entry storage
    key_event_t mem [fifo_depth];

    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    logic [fifo_aw:0]   count;
    logic               full;
    logic               empty;
    logic               do_push;
    logic               do_pop;

    assign full    = (count == (fifo_aw+1)'(fifo_depth));
    assign empty   = (count == '0);
    // Keyboard cannot be stalled, a push into a full buffer is lost
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head  = mem[rd_ptr];
    assign level = count;

    // ----------------------------------------------------------------------
    // Pointers and fill count
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap naturally at the power-of-two depth
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // ----------------------------------------------------------------------
    // Overflow flag
    // ----------------------------------------------------------------------

    // A new loss in the clearing cycle keeps the flag set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (push && full) begin
            overflow <= 1'b1;
        end else if (ovf_clr) begin
            overflow <= 1'b0;
        end
    end

endmodule

// ==== design/ps2_frame_rx.sv ====
// PS/2 line synchronizers, clock falling-edge detect, 11-bit frame shifter and checks
`timescale 1ns/100ps

module ps2_frame_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic       ctrl_enable,
    input  logic       ctrl_parity,
    output logic [7:0] rx_byte,
    output logic       byte_valid,
    output logic       frame_err
);

    // ----------------------------------------------------------------------
    // Synchronizers and edge detect
    // ----------------------------------------------------------------------

    // Two flops per line, idle level of the bus is high
    logic clk_s1;
    logic clk_s2;
    logic data_s1;
    logic data_s2;

    // Delayed copy of the synchronized clock
    logic clk_prev;
    logic clk_fall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_s1   <= 1'b1;
            clk_s2   <= 1'b1;
            data_s1  <= 1'b1;
            data_s2  <= 1'b1;
            clk_prev <= 1'b1;
        end else begin
            clk_s1   <= ps2_clk;
            clk_s2   <= clk_s1;
            data_s1  <= ps2_data;
            data_s2  <= data_s1;
            clk_prev <= clk_s2;
        end
    end

    // High for one cycle after the line drops
    assign clk_fall = clk_prev & ~clk_s2;

    // ----------------------------------------------------------------------
    // Frame shifter
    // ----------------------------------------------------------------------

    // Bit index within the frame, 0 means waiting for a start bit
    logic [3:0] bit_cnt;
    // Data bits LSB first, then parity in bit 8
    logic [8:0] shift_q;
    logic       stop_ok;
    logic       parity_ok;
    logic       frame_good;

    // Odd parity over data plus parity bit gives a 1
    assign stop_ok    = data_s2;
    assign parity_ok  = ^shift_q;
    assign frame_good = stop_ok && (!ctrl_parity || parity_ok);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt    <= 4'd0;
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
            if (!ctrl_enable) begin
                // Receiver parked, any partial frame is dropped
                bit_cnt <= 4'd0;
            end else if (clk_fall) begin
                if (bit_cnt == 4'd0) begin
                    // Start bit must be low
                    if (!data_s2) begin
                        bit_cnt <= 4'd1;
                    end
                end else if (bit_cnt < 4'd10) begin
                    bit_cnt <= bit_cnt + 4'd1;
                end else begin
                    // Stop bit, judge the whole frame
                    bit_cnt    <= 4'd0;
                    byte_valid <= frame_good;
                    frame_err  <= ~frame_good;
                end
            end
        end
    end

    // Payload path, data and parity shifted in, byte taken at the stop bit
    always_ff @(posedge clk) begin
        if (ctrl_enable && clk_fall) begin
            if (bit_cnt != 4'd0 && bit_cnt < 4'd10) begin
                shift_q <= {data_s2, shift_q[8:1]};
            end
            if (bit_cnt == 4'd10) begin
                rx_byte <= shift_q[7:0];
            end
        end
    end

endmodule

// ==== design/ps2_kbd_pkg.sv ====
// Shared sizes, host register map, set-2 prefix codes and the key event word
package ps2_kbd_pkg;

    // ----------------------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------------------

    // Key event FIFO entries and its pointer width
    localparam int fifo_depth = 8;
    localparam int fifo_aw    = 3;

    // Event word is ext + brk + 8-bit scan code
    localparam int event_w    = 10;

    // Host bus
    localparam int addr_w     = 2;
    localparam int data_w     = 16;

    // Rejected frame counter, saturating
    localparam int err_cnt_w  = 8;

    // ----------------------------------------------------------------------
    // Host register map
    // ----------------------------------------------------------------------

    // Bit 0 enable, bit 1 parity check enable
    localparam logic [addr_w-1:0] reg_ctrl   = 2'd0;
    // Level in 3:0, sticky overflow in 4, not empty in 5
    localparam logic [addr_w-1:0] reg_status = 2'd1;
    // Read returns the FIFO head and pops it
    localparam logic [addr_w-1:0] reg_event  = 2'd2;
    // Frame error count, cleared by any write
    localparam logic [addr_w-1:0] reg_errors = 2'd3;

    // Both receiver features on out of reset
    localparam logic [1:0] ctrl_rst_val = 2'b11;

    // ----------------------------------------------------------------------
    // Scan code set 2 prefixes
    // ----------------------------------------------------------------------
    localparam logic [7:0] code_ext = 8'hE0;
    localparam logic [7:0] code_brk = 8'hF0;

    // Built by fields in the decoder, returned raw to the host
    typedef union packed {
        struct packed {
            logic       ext;
            logic       brk;
            logic [7:0] code;
        } f;
        logic [event_w-1:0] raw;
    } key_event_t;

endpackage

// ==== design/scan_decoder.sv ====
// Set-2 prefix state machine folding E0 and F0 into single key events
`timescale 1ns/100ps

module scan_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              rx_byte,
    input  logic                    byte_valid,
    output ps2_kbd_pkg::key_event_t ev_data,
    output logic                    ev_push
);

    import ps2_kbd_pkg::*;

    // Prefixes seen since the last event
    logic ext_pend;
    logic brk_pend;
    logic is_ext;
    logic is_brk;

    assign is_ext = (rx_byte == code_ext);
    assign is_brk = (rx_byte == code_brk);

    // ----------------------------------------------------------------------
    // Pending flags and push strobe
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ext_pend <= 1'b0;
            brk_pend <= 1'b0;
            ev_push  <= 1'b0;
        end else begin
            ev_push <= 1'b0;
            if (byte_valid) begin
                if (is_ext) begin
                    ext_pend <= 1'b1;
                end else if (is_brk) begin
                    brk_pend <= 1'b1;
                end else begin
                    // Ordinary code closes the sequence
                    ev_push  <= 1'b1;
                    ext_pend <= 1'b0;
                    brk_pend <= 1'b0;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Event word
    // ----------------------------------------------------------------------

    // Loaded with the strobe, held until the next event
    always_ff @(posedge clk) begin
        if (byte_valid && !is_ext && !is_brk) begin
            ev_data.f.ext  <= ext_pend;
            ev_data.f.brk  <= brk_pend;
            ev_data.f.code <= rx_byte;
        end
    end

endmodule

// ==== sources.f ====
design/ps2_kbd_pkg.sv
design/ps2_frame_rx.sv
design/scan_decoder.sv
design/key_event_fifo.sv
design/kbd_regs.sv
design/kbd_top.sv
test/tb_clock.sv
test/tb_keyboard_model.sv
test/tb_kbd.sv

// ==== test/tb_clock.sv ====
// Testbench clock source and power-on reset generator
`timescale 1ns/100ps

module tb_clock #(
    parameter int period       = 100,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst_n
);

    // Free-running system clock
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset held low from time zero, released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== test/tb_kbd.sv ====
// Testbench top: stimulus table, host handshake tasks, LFSR, check task and timeout
`timescale 1ns/100ps

module tb_kbd;

    import ps2_kbd_pkg::*;

    // Expected outcome of one table entry
    localparam logic [1:0] kind_none  = 2'd0;
    localparam logic [1:0] kind_event = 2'd1;
    localparam logic [1:0] kind_error = 2'd2;

    localparam int n_entries  = 19;
    localparam int max_seq    = 3;
    localparam int ovf_events = 9;
    // Frames of 11 bits, 16 cycles per bit, doubled, plus host traffic margin
    localparam int cycle_limit = (n_entries * max_seq + ovf_events) * 11 * 16 * 2 + 10000;

    // One row: ctrl to write, byte sequence, corruption of the last byte, expectation
    typedef struct packed {
        logic [1:0]      ctrl;
        logic [1:0]      len;
        logic [2:0][7:0] seq;
        logic            bad_par;
        logic            bad_stop;
        logic [1:0]      kind;
        logic [9:0]      exp_ev;
    } vec_t;

    logic              clk;
    logic              rst_n;
    logic              ps2_clk;
    logic              ps2_data;
    logic              req;
    logic              wr;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic              ack;
    logic [data_w-1:0] rdata;

    vec_t        vectors [n_entries];
    int          n_built     = 0;
    int          exp_errors  = 0;
    int          error_count = 0;
    int          cycle_count = 0;
    logic [31:0] lfsr_state  = 32'd83994;

    tb_clock clkgen (.clk(clk), .rst_n(rst_n));

    tb_keyboard_model kbd (.clk(clk), .ps2_clk(ps2_clk), .ps2_data(ps2_data));

    kbd_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .req      (req),
        .wr       (wr),
        .addr     (addr),
        .wdata    (wdata),
        .ack      (ack),
        .rdata    (rdata)
    );

    // ----------------------------------------------------------------------
    // Checking and random bytes
    // ----------------------------------------------------------------------
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("** Error at %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, got, expected);
        end
    endtask

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // Eight steps per byte, prefix codes are drawn again
    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        int         i;
        do begin
            for (i = 0; i < 8; i++) begin
                lfsr_state = lfsr_step(lfsr_state);
                b = {lfsr_state[0], b[7:1]};
            end
        end while (b == code_ext || b == code_brk);
        return b;
    endfunction

    // ----------------------------------------------------------------------
    // Host port, four-phase
    // ----------------------------------------------------------------------

    // Ack must follow each req edge by exactly one clock
    task automatic run_handshake(input logic w, input logic [addr_w-1:0] a,
                                 input logic [data_w-1:0] d, output logic [data_w-1:0] q);
        int delay;
        check_value("ack idle before req", ack, 1'b0);
        @(posedge clk);
        req   <= 1'b1;
        wr    <= w;
        addr  <= a;
        wdata <= d;
        delay = 0;
        @(negedge clk);
        while (ack !== 1'b1) begin
            delay++;
            @(negedge clk);
        end
        check_value("ack rise delay", delay, 1);
        q = rdata;
        @(posedge clk);
        req <= 1'b0;
        delay = 0;
        @(negedge clk);
        while (ack !== 1'b0) begin
            delay++;
            @(negedge clk);
        end
        check_value("ack fall delay", delay, 1);
    endtask

    task automatic read_reg(input logic [addr_w-1:0] a, output logic [data_w-1:0] q);
        run_handshake(1'b0, a, '0, q);
    endtask

    task automatic write_reg(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
        logic [data_w-1:0] unused;
        run_handshake(1'b1, a, d, unused);
    endtask

    // ----------------------------------------------------------------------
    // Stimulus table
    // ----------------------------------------------------------------------

    // Expected event word is ext, brk, then the final byte of the sequence
    task automatic add_entry(input logic [1:0] ctrl, input logic [1:0] len,
                             input logic [7:0] b0, input logic [7:0] b1,
                             input logic [7:0] b2, input logic bad_par,
                             input logic bad_stop, input logic [1:0] kind,
                             input logic ext, input logic brk);
        vec_t v;
        v.ctrl     = ctrl;
        v.len      = len;
        v.seq      = {b2, b1, b0};
        v.bad_par  = bad_par;
        v.bad_stop = bad_stop;
        v.kind     = kind;
        v.exp_ev   = {ext, brk, v.seq[len - 1]};
        vectors[n_built] = v;
        n_built++;
    endtask

    task automatic build_vectors();
        // Plain bytes
        add_entry(2'd3, 2'd1, 8'h1C, 8'h00, 8'h00, 0, 0, kind_event, 0, 0);
        add_entry(2'd3, 2'd1, random_byte(), 8'h00, 8'h00, 0, 0, kind_event, 0, 0);
        add_entry(2'd3, 2'd1, random_byte(), 8'h00, 8'h00, 0, 0, kind_event, 0, 0);
        add_entry(2'd3, 2'd1, random_byte(), 8'h00, 8'h00, 0, 0, kind_event, 0, 0);
        // Prefix folding
        add_entry(2'd3, 2'd2, code_brk, 8'h1C, 8'h00, 0, 0, kind_event, 0, 1);
        add_entry(2'd3, 2'd2, code_ext, 8'h75, 8'h00, 0, 0, kind_event, 1, 0);
        add_entry(2'd3, 2'd3, code_ext, code_brk, 8'h75, 0, 0, kind_event, 1, 1);
        // Lone prefix stays pending into the next entry
        add_entry(2'd3, 2'd1, code_brk, 8'h00, 8'h00, 0, 0, kind_none, 0, 0);
        add_entry(2'd3, 2'd2, code_ext, 8'h1C, 8'h00, 0, 0, kind_event, 1, 1);
        add_entry(2'd3, 2'd1, code_ext, 8'h00, 8'h00, 0, 0, kind_none, 0, 0);
        add_entry(2'd3, 2'd1, 8'h5A, 8'h00, 8'h00, 0, 0, kind_event, 1, 0);
        // Frame errors, then parity check off
        add_entry(2'd3, 2'd1, 8'h23, 8'h00, 8'h00, 1, 0, kind_error, 0, 0);
        add_entry(2'd3, 2'd1, 8'h23, 8'h00, 8'h00, 0, 1, kind_error, 0, 0);
        add_entry(2'd1, 2'd1, 8'h2B, 8'h00, 8'h00, 1, 0, kind_event, 0, 0);
        add_entry(2'd1, 2'd1, 8'h2B, 8'h00, 8'h00, 0, 1, kind_error, 0, 0);
        // Receiver disabled, then enabled again
        add_entry(2'd2, 2'd1, 8'h34, 8'h00, 8'h00, 0, 0, kind_none, 0, 0);
        add_entry(2'd0, 2'd1, 8'h34, 8'h00, 8'h00, 0, 1, kind_none, 0, 0);
        add_entry(2'd3, 2'd1, random_byte(), 8'h00, 8'h00, 0, 0, kind_event, 0, 0);
        add_entry(2'd3, 2'd1, random_byte(), 8'h00, 8'h00, 1, 0, kind_error, 0, 0);
    endtask

    task automatic run_entry(input int idx);
        vec_t              v;
        logic [data_w-1:0] rd;
        int                k;
        v = vectors[idx];
        write_reg(reg_ctrl, data_w'(v.ctrl));
        read_reg(reg_ctrl, rd);
        check_value("ctrl readback", rd, data_w'(v.ctrl));
        // Corruption applies to the last byte only
        for (k = 0; k < v.len; k++) begin
            kbd.send_frame(v.seq[k], (k == v.len - 1) && v.bad_par,
                           (k == v.len - 1) && v.bad_stop);
        end
        if (v.kind == kind_event) begin
            // Poll until the event shows up
            do begin
                read_reg(reg_status, rd);
            end while (rd[5] !== 1'b1);
            check_value("status with one event", rd, 16'h0021);
            read_reg(reg_event, rd);
            check_value("event word", rd, data_w'(v.exp_ev));
        end
        // Running count of rejected frames since reset
        if (v.kind == kind_error) begin
            exp_errors++;
        end
        read_reg(reg_status, rd);
        check_value("status after entry", rd, 16'h0000);
        read_reg(reg_errors, rd);
        check_value("error count", rd, exp_errors);
    endtask

    // ----------------------------------------------------------------------
    // FIFO overflow
    // ----------------------------------------------------------------------
    task automatic check_overflow();
        logic [7:0]        sent [ovf_events];
        logic [data_w-1:0] rd;
        int                i;
        for (i = 0; i < ovf_events; i++) begin
            sent[i] = random_byte();
            kbd.send_frame(sent[i], 1'b0, 1'b0);
        end
        // Full, overflow and not empty; the read clears overflow
        read_reg(reg_status, rd);
        check_value("status when overflowed", rd, 16'h0038);
        read_reg(reg_status, rd);
        check_value("status after overflow clear", rd, 16'h0028);
        // Ninth event was lost
        for (i = 0; i < fifo_depth; i++) begin
            read_reg(reg_event, rd);
            check_value("event order after overflow", rd, data_w'(sent[i]));
        end
        read_reg(reg_event, rd);
        check_value("read of empty FIFO", rd, 16'h0000);
        read_reg(reg_status, rd);
        check_value("status when drained", rd, 16'h0000);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        logic [data_w-1:0] rd;
        int                i;
        req   = 1'b0;
        wr    = 1'b0;
        addr  = '0;
        wdata = '0;
        build_vectors();
        wait (rst_n === 1'b1);
        repeat (2) @(posedge clk);
        // Reset values
        read_reg(reg_ctrl, rd);
        check_value("ctrl after reset", rd, 16'h0003);
        read_reg(reg_status, rd);
        check_value("status after reset", rd, 16'h0000);
        read_reg(reg_errors, rd);
        check_value("errors after reset", rd, 16'h0000);
        for (i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        // Total of rejected frames, then clear by write
        read_reg(reg_errors, rd);
        check_value("error total", rd, exp_errors);
        write_reg(reg_errors, 16'h00A5);
        read_reg(reg_errors, rd);
        check_value("errors after clear", rd, 16'h0000);
        check_overflow();
        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Run limit
    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== test/tb_keyboard_model.sv ====
// PS/2 keyboard model with a frame send task and optional parity or stop corruption
`timescale 1ns/100ps

module tb_keyboard_model (
    input  logic clk,
    output logic ps2_clk,
    output logic ps2_data
);

    // System clock cycles per PS/2 half bit
    localparam int half_bit = 8;

    // Idle bus is high on both lines
    initial begin
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
    end

    // One bit cell: data moves while the clock is high, host samples on the fall
    task automatic drive_bit(input logic value);
        @(posedge clk);
        ps2_data <= value;
        repeat (half_bit) @(posedge clk);
        ps2_clk <= 1'b0;
        repeat (half_bit) @(posedge clk);
        ps2_clk <= 1'b1;
    endtask

    // ----------------------------------------------------------------------
    // Frame: start 0, data LSB first, odd parity, stop 1
    // ----------------------------------------------------------------------
    task automatic send_frame(input logic [7:0] code, input logic bad_parity,
                              input logic bad_stop);
        logic [10:0] frame;
        int          i;
        frame[0]    = 1'b0;
        frame[8:1]  = code;
        // Parity makes the count of ones odd, flipped on request
        frame[9]    = ~(^code) ^ bad_parity;
        frame[10]   = ~bad_stop;
        for (i = 0; i < 11; i++) begin
            drive_bit(frame[i]);
        end
        // Release data and leave a gap between frames
        @(posedge clk);
        ps2_data <= 1'b1;
        repeat (2 * half_bit) @(posedge clk);
    endtask

endmodule
